/* Makefile */
TOP = tb_datapath

simulate:
	verilator --binary -j 0 --timescale 1ns/10ps --top-module $(TOP) -f datapath.f -o sim
	./obj_dir/sim | tee sim.log
	grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: simulate clean

/* datapath.f */
rtl/datapath_pkg.sv
rtl/register_file.sv
rtl/select_encode.sv
rtl/bus_mux.sv
rtl/alu.sv
rtl/memory_unit.sv
rtl/con_ff.sv
rtl/datapath.sv
testbench/tb_datapath.sv

/* rtl/alu.sv */
`timescale 1ns/10ps

module alu (
    input  datapath_pkg::alu_op_t op,
    input  datapath_pkg::word_t   a,
    input  datapath_pkg::word_t   b,
    output logic [63:0]           result
);

    logic [4:0]         sh;
    logic [63:0]        dbl;
    logic [63:0]        rot_r;
    logic [63:0]        rot_l;
    logic signed [63:0] prod;
    logic signed [31:0] quot;
    logic signed [31:0] rem;

    always_comb begin
        sh    = b[4:0];
        // doubled word makes rotates plain shifts
        dbl   = {a, a};
        rot_r = dbl >> sh;
        rot_l = dbl << sh;
        prod  = $signed(a) * $signed(b);

        // divide by zero yields zero
        if (b == '0) begin
            quot = '0;
            rem  = '0;
        end else begin
            quot = $signed(a) / $signed(b);
            rem  = $signed(a) % $signed(b);
        end

        case (op)
            datapath_pkg::ALU_ADD:  result = {32'd0, a + b};
            datapath_pkg::ALU_SUB:  result = {32'd0, a - b};
            datapath_pkg::ALU_AND:  result = {32'd0, a & b};
            datapath_pkg::ALU_OR:   result = {32'd0, a | b};
            datapath_pkg::ALU_SHR:  result = {32'd0, a >> sh};
            datapath_pkg::ALU_SHRA: result = {32'd0, $signed(a) >>> sh};
            datapath_pkg::ALU_SHL:  result = {32'd0, a << sh};
            datapath_pkg::ALU_ROR:  result = {32'd0, rot_r[31:0]};
            datapath_pkg::ALU_ROL:  result = {32'd0, rot_l[63:32]};
            datapath_pkg::ALU_MUL:  result = prod;
            // remainder high, quotient low
            datapath_pkg::ALU_DIV:  result = {rem, quot};
            datapath_pkg::ALU_NEG:  result = {32'd0, -b};
            datapath_pkg::ALU_NOT:  result = {32'd0, ~b};
            default:                result = '0;
        endcase
    end

endmodule

/* rtl/bus_mux.sv */
`timescale 1ns/10ps

module bus_mux (
    input  datapath_pkg::bus_src_t src,
    input  logic [15:0]            r_sel_out,
    input  datapath_pkg::word_t    r_data [16],
    input  datapath_pkg::word_t    hi,
    input  datapath_pkg::word_t    lo,
    input  datapath_pkg::word_t    zhigh,
    input  datapath_pkg::word_t    zlow,
    input  datapath_pkg::word_t    pc,
    input  datapath_pkg::word_t    mdr,
    input  datapath_pkg::word_t    in_port,
    input  datapath_pkg::word_t    c_sext,
    output datapath_pkg::word_t    bus
);

    // codes 0 to 15 pick a general register
    localparam logic [4:0] SEL_HI      = 5'd16;
    localparam logic [4:0] SEL_LO      = 5'd17;
    localparam logic [4:0] SEL_ZHIGH   = 5'd18;
    localparam logic [4:0] SEL_ZLOW    = 5'd19;
    localparam logic [4:0] SEL_PC      = 5'd20;
    localparam logic [4:0] SEL_MDR     = 5'd21;
    localparam logic [4:0] SEL_IN_PORT = 5'd22;
    localparam logic [4:0] SEL_C       = 5'd23;
    localparam logic [4:0] SEL_NONE    = 5'd31;

    logic [4:0] sel;

    // later hits override, so lowest priority goes first
    always_comb begin
        sel = SEL_NONE;
        for (int i = 0; i < 16; i++) begin
            if (r_sel_out[i]) begin
                sel = 5'(i);
            end
        end
        if (src.hi_out)      sel = SEL_HI;
        if (src.lo_out)      sel = SEL_LO;
        if (src.zhigh_out)   sel = SEL_ZHIGH;
        if (src.zlow_out)    sel = SEL_ZLOW;
        if (src.pc_out)      sel = SEL_PC;
        if (src.mdr_out)     sel = SEL_MDR;
        if (src.in_port_out) sel = SEL_IN_PORT;
        if (src.c_out)       sel = SEL_C;
    end

    always_comb begin
        if (sel < 5'd16) begin
            bus = r_data[sel[3:0]];
        end else begin
            case (sel)
                SEL_HI:      bus = hi;
                SEL_LO:      bus = lo;
                SEL_ZHIGH:   bus = zhigh;
                SEL_ZLOW:    bus = zlow;
                SEL_PC:      bus = pc;
                SEL_MDR:     bus = mdr;
                SEL_IN_PORT: bus = in_port;
                SEL_C:       bus = c_sext;
                default:     bus = '0;
            endcase
        end
    end

endmodule

/* rtl/con_ff.sv */
`timescale 1ns/10ps

module con_ff (
    input  logic                 clk,
    input  logic                 reset,
    input  datapath_pkg::instr_u ir,
    input  datapath_pkg::word_t  bus,
    input  logic                 con_in,
    output logic                 con
);

    logic cond;

    // branch if zero, nonzero, positive, negative
    always_comb begin
        case (ir.b_form.c2[1:0])
            2'd0:    cond = (bus == '0);
            2'd1:    cond = (bus != '0);
            2'd2:    cond = (bus != '0) && !bus[31];
            default: cond = bus[31];
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            con <= 1'b0;
        end else if (con_in) begin
            con <= cond;
        end
    end

endmodule

/* rtl/datapath.sv */
`timescale 1ns/10ps

module datapath #(
    parameter int                  MEM_ADDR_BITS = 9,
    parameter datapath_pkg::word_t PC_INIT       = '0
) (
    input  logic                clk,
    input  logic                reset,
    input  datapath_pkg::ctrl_t ctrl,
    input  datapath_pkg::word_t in_data,
    output datapath_pkg::word_t out_data,
    output logic                con
);

    datapath_pkg::word_t  bus;
    datapath_pkg::word_t  pc;
    datapath_pkg::instr_u ir;
    datapath_pkg::word_t  y;
    datapath_pkg::word_t  hi;
    datapath_pkg::word_t  lo;
    datapath_pkg::word_t  in_port;
    datapath_pkg::word_t  mdr_data;
    datapath_pkg::word_t  c_sext;
    datapath_pkg::word_t  r_data [16];
    logic [63:0]          z;
    logic [63:0]          alu_result;
    logic [15:0]          r_en;
    logic [15:0]          r_sel_out;

    register_file u_register_file (
        .clk    (clk),
        .reset  (reset),
        .bus    (bus),
        .r_en   (r_en),
        .r_out  (r_sel_out),
        .ba_out (ctrl.src.ba_out),
        .r_data (r_data)
    );

    select_encode u_select_encode (
        .ir        (ir),
        .gra       (ctrl.gra),
        .grb       (ctrl.grb),
        .grc       (ctrl.grc),
        .r_in      (ctrl.r_in),
        .r_out     (ctrl.src.r_out),
        .ba_out    (ctrl.src.ba_out),
        .r_en      (r_en),
        .r_sel_out (r_sel_out),
        .c_sext    (c_sext)
    );

    bus_mux u_bus_mux (
        .src       (ctrl.src),
        .r_sel_out (r_sel_out),
        .r_data    (r_data),
        .hi        (hi),
        .lo        (lo),
        .zhigh     (z[63:32]),
        .zlow      (z[31:0]),
        .pc        (pc),
        .mdr       (mdr_data),
        .in_port   (in_port),
        .c_sext    (c_sext),
        .bus       (bus)
    );

    // Y is the held operand, the bus the other
    alu u_alu (
        .op     (ctrl.op),
        .a      (y),
        .b      (bus),
        .result (alu_result)
    );

    memory_unit #(
        .MEM_ADDR_BITS (MEM_ADDR_BITS)
    ) u_memory_unit (
        .clk      (clk),
        .reset    (reset),
        .bus      (bus),
        .mar_en   (ctrl.mar_en),
        .mdr_en   (ctrl.mdr_en),
        .read     (ctrl.read),
        .write    (ctrl.write),
        .mdr_data (mdr_data)
    );

    con_ff u_con_ff (
        .clk    (clk),
        .reset  (reset),
        .ir     (ir),
        .bus    (bus),
        .con_in (ctrl.con_in),
        .con    (con)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= PC_INIT;
            ir       <= '0;
            y        <= '0;
            z        <= '0;
            hi       <= '0;
            lo       <= '0;
            in_port  <= '0;
            out_data <= '0;
        end else begin
            // a bus load wins over increment
            if (ctrl.pc_en) begin
                pc <= bus;
            end else if (ctrl.inc_pc) begin
                pc <= pc + 32'd1;
            end
            if (ctrl.ir_en) begin
                ir <= bus;
            end
            if (ctrl.y_en) begin
                y <= bus;
            end
            if (ctrl.z_en) begin
                z <= alu_result;
            end
            if (ctrl.hi_en) begin
                hi <= bus;
            end
            if (ctrl.lo_en) begin
                lo <= bus;
            end
            // input port samples every edge
            in_port <= in_data;
            if (ctrl.out_port_en) begin
                out_data <= bus;
            end
        end
    end

endmodule

/* rtl/datapath_pkg.sv */
package datapath_pkg;

    localparam int WORD_BITS = 32;

    typedef logic [WORD_BITS-1:0] word_t;
    typedef logic [3:0] reg_idx_t;

    // opcodes follow the instruction set numbering
    typedef enum logic [4:0] {
        ALU_ADD  = 5'd3,
        ALU_SUB  = 5'd4,
        ALU_AND  = 5'd5,
        ALU_OR   = 5'd6,
        ALU_SHR  = 5'd7,
        ALU_SHRA = 5'd8,
        ALU_SHL  = 5'd9,
        ALU_ROR  = 5'd10,
        ALU_ROL  = 5'd11,
        ALU_MUL  = 5'd15,
        ALU_DIV  = 5'd16,
        ALU_NEG  = 5'd17,
        ALU_NOT  = 5'd18
    } alu_op_t;

    // three-register format
    typedef struct packed {
        logic [4:0] opcode;
        reg_idx_t   ra;
        reg_idx_t   rb;
        reg_idx_t   rc;
        logic [14:0] unused;
    } r_form_t;

    // c2 overlays rb in the branch and immediate format
    typedef struct packed {
        logic [4:0]  opcode;
        reg_idx_t    ra;
        logic [3:0]  c2;
        logic [18:0] imm;
    } b_form_t;

    typedef union packed {
        r_form_t r_form;
        b_form_t b_form;
    } instr_u;

    typedef struct packed {
        logic r_out;
        logic ba_out;
        logic hi_out;
        logic lo_out;
        logic zhigh_out;
        logic zlow_out;
        logic pc_out;
        logic mdr_out;
        logic in_port_out;
        logic c_out;
    } bus_src_t;

    typedef struct packed {
        bus_src_t src;
        logic     gra;
        logic     grb;
        logic     grc;
        logic     r_in;
        logic     hi_en;
        logic     lo_en;
        logic     y_en;
        logic     z_en;
        logic     pc_en;
        logic     inc_pc;
        logic     ir_en;
        logic     mar_en;
        logic     mdr_en;
        logic     read;
        logic     write;
        logic     con_in;
        logic     out_port_en;
        alu_op_t  op;
    } ctrl_t;

endpackage

/* rtl/memory_unit.sv */
`timescale 1ns/10ps

module memory_unit #(
    parameter int MEM_ADDR_BITS = 9
) (
    input  logic                clk,
    input  logic                reset,
    input  datapath_pkg::word_t bus,
    input  logic                mar_en,
    input  logic                mdr_en,
    input  logic                read,
    input  logic                write,
    output datapath_pkg::word_t mdr_data
);

    datapath_pkg::word_t mar;
    datapath_pkg::word_t mdr;
    datapath_pkg::word_t ram_rd;
    datapath_pkg::word_t ram [2**MEM_ADDR_BITS];

    // combinational read at the current MAR
    assign ram_rd = ram[mar[MEM_ADDR_BITS-1:0]];

    always_ff @(posedge clk) begin
        if (reset) begin
            mar <= '0;
            mdr <= '0;
        end else begin
            if (mar_en) begin
                mar <= bus;
            end
            // read selects memory over the bus
            if (mdr_en) begin
                mdr <= read ? ram_rd : bus;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (write) begin
            ram[mar[MEM_ADDR_BITS-1:0]] <= mdr;
        end
    end

    assign mdr_data = mdr;

endmodule

/* rtl/register_file.sv */
`timescale 1ns/10ps

module register_file (
    input  logic                clk,
    input  logic                reset,
    input  datapath_pkg::word_t bus,
    input  logic [15:0]         r_en,
    input  logic [15:0]         r_out,
    input  logic                ba_out,
    output datapath_pkg::word_t r_data [16]
);

    datapath_pkg::word_t regs [16];

    always_ff @(posedge clk) begin
        for (int i = 0; i < 16; i++) begin
            if (reset) begin
                regs[i] <= '0;
            end else if (r_en[i]) begin
                regs[i] <= bus;
            end
        end
    end

    // only strobed registers present a value
    always_comb begin
        for (int i = 0; i < 16; i++) begin
            r_data[i] = r_out[i] ? regs[i] : '0;
        end
        // R0 acts as a zero base for base-plus-offset
        if (ba_out) begin
            r_data[0] = '0;
        end
    end

endmodule

/* rtl/select_encode.sv */
`timescale 1ns/10ps

module select_encode (
    input  datapath_pkg::instr_u ir,
    input  logic                 gra,
    input  logic                 grb,
    input  logic                 grc,
    input  logic                 r_in,
    input  logic                 r_out,
    input  logic                 ba_out,
    output logic [15:0]          r_en,
    output logic [15:0]          r_sel_out,
    output datapath_pkg::word_t  c_sext
);

    datapath_pkg::reg_idx_t sel;
    logic [15:0]            dec;

    // ra has priority over rb and rc
    always_comb begin
        sel = '0;
        if (gra) begin
            sel = ir.r_form.ra;
        end else if (grb) begin
            sel = ir.r_form.rb;
        end else if (grc) begin
            sel = ir.r_form.rc;
        end
    end

    // no field selected means no register touched
    assign dec = (gra | grb | grc) ? (16'd1 << sel) : 16'd0;

    assign r_en      = r_in ? dec : 16'd0;
    assign r_sel_out = (r_out | ba_out) ? dec : 16'd0;

    // 19-bit immediate to a full word
    assign c_sext = {{13{ir.b_form.imm[18]}}, ir.b_form.imm};

endmodule

/* testbench/tb_datapath.sv */
`timescale 1ns/10ps

module tb_datapath;

    localparam datapath_pkg::word_t PC_INIT = 32'h0000_0100;
    localparam int unsigned         SEED    = 32'h1d7fa04a;

    typedef enum logic [1:0] {
        CHK_NONE,
        CHK_WORD,
        CHK_FLAG
    } check_kind_t;

    // one stimulus step and what it should leave behind
    typedef struct packed {
        datapath_pkg::ctrl_t ctrl;
        datapath_pkg::word_t din;
        check_kind_t         kind;
        datapath_pkg::word_t expected;
    } step_t;

    logic                clk;
    logic                reset;
    datapath_pkg::ctrl_t ctrl;
    datapath_pkg::word_t in_data;
    datapath_pkg::word_t out_data;
    logic                con;

    step_t steps[$];
    string labels[$];
    bit    table_ready;
    int    error_count;

    datapath #(
        .MEM_ADDR_BITS (9),
        .PC_INIT       (PC_INIT)
    ) u_dut (
        .clk      (clk),
        .reset    (reset),
        .ctrl     (ctrl),
        .in_data  (in_data),
        .out_data (out_data),
        .con      (con)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic datapath_pkg::ctrl_t idle_ctrl();
        datapath_pkg::ctrl_t c;
        c    = '0;
        c.op = datapath_pkg::ALU_ADD;
        return c;
    endfunction

    function automatic datapath_pkg::word_t encode_r(logic [4:0] opcode,
            datapath_pkg::reg_idx_t ra, datapath_pkg::reg_idx_t rb,
            datapath_pkg::reg_idx_t rc);
        return {opcode, ra, rb, rc, 15'd0};
    endfunction

    function automatic datapath_pkg::word_t encode_b(datapath_pkg::reg_idx_t ra,
            logic [3:0] c2, logic [18:0] imm);
        return {5'd0, ra, c2, imm};
    endfunction

    function automatic datapath_pkg::word_t sign_extend(logic [18:0] imm);
        return $signed({imm, 13'd0}) >>> 13;
    endfunction

    function automatic logic cond_expect(int code, datapath_pkg::word_t v);
        case (code)
            0:       return v == 32'd0;
            1:       return v != 32'd0;
            2:       return $signed(v) > 0;
            default: return $signed(v) < 0;
        endcase
    endfunction

    // reference results with Y in a and the bus in b
    function automatic logic [63:0] alu_expect(datapath_pkg::alu_op_t op,
            datapath_pkg::word_t a, datapath_pkg::word_t b);
        datapath_pkg::word_t x;
        datapath_pkg::word_t ua;
        datapath_pkg::word_t ub;
        datapath_pkg::word_t q;
        datapath_pkg::word_t r;
        logic [63:0]         wide;
        int                  s;
        s = int'(b[4:0]);
        x = a;
        case (op)
            datapath_pkg::ALU_ADD: return {32'd0, a + b};
            datapath_pkg::ALU_SUB: return {32'd0, a - b};
            datapath_pkg::ALU_AND: return {32'd0, a & b};
            datapath_pkg::ALU_OR:  return {32'd0, a | b};
            datapath_pkg::ALU_SHR: return {32'd0, a >> s};
            datapath_pkg::ALU_SHL: return {32'd0, a << s};
            datapath_pkg::ALU_SHRA: begin
                wide = {{32{a[31]}}, a} >> s;
                return {32'd0, wide[31:0]};
            end
            datapath_pkg::ALU_ROR: begin
                repeat (s) x = {x[0], x[31:1]};
                return {32'd0, x};
            end
            datapath_pkg::ALU_ROL: begin
                repeat (s) x = {x[30:0], x[31]};
                return {32'd0, x};
            end
            datapath_pkg::ALU_MUL: return longint'($signed(a)) * longint'($signed(b));
            datapath_pkg::ALU_DIV: begin
                if (b == 32'd0) begin
                    return 64'd0;
                end
                // magnitudes first and signs after
                ua = a[31] ? -a : a;
                ub = b[31] ? -b : b;
                q  = ua / ub;
                r  = ua % ub;
                if (a[31] != b[31]) begin
                    q = -q;
                end
                if (a[31]) begin
                    r = -r;
                end
                return {r, q};
            end
            datapath_pkg::ALU_NEG: return {32'd0, 32'd0 - b};
            datapath_pkg::ALU_NOT: return {32'd0, ~b};
            default:               return 64'd0;
        endcase
    endfunction

    task automatic push_step(datapath_pkg::ctrl_t c, datapath_pkg::word_t din,
            check_kind_t kind, datapath_pkg::word_t expected, string label);
        step_t s;
        s.ctrl     = c;
        s.din      = din;
        s.kind     = kind;
        s.expected = expected;
        steps.push_back(s);
        labels.push_back(label);
    endtask

    // instruction through the input port into IR with next_in behind it
    task automatic load_ir(datapath_pkg::word_t instr, datapath_pkg::word_t next_in);
        datapath_pkg::ctrl_t c;
        push_step(idle_ctrl(), instr, CHK_NONE, '0, "");
        c                 = idle_ctrl();
        c.src.in_port_out = 1'b1;
        c.ir_en           = 1'b1;
        push_step(c, next_in, CHK_NONE, '0, "");
    endtask

    task automatic write_reg(datapath_pkg::reg_idx_t idx, datapath_pkg::word_t value);
        datapath_pkg::ctrl_t c;
        load_ir(encode_r(5'd0, idx, 4'd0, 4'd0), value);
        c                 = idle_ctrl();
        c.src.in_port_out = 1'b1;
        c.gra             = 1'b1;
        c.r_in            = 1'b1;
        push_step(c, '0, CHK_NONE, '0, "");
    endtask

    task automatic run_alu_case(datapath_pkg::alu_op_t op, datapath_pkg::word_t a,
            datapath_pkg::word_t b);
        datapath_pkg::ctrl_t c;
        logic [63:0]         res;
        string               tag;
        res = alu_expect(op, a, b);
        tag = $sformatf("%s a=%h b=%h", op.name(), a, b);
        write_reg(4'd2, a);
        write_reg(4'd3, b);
        load_ir(encode_r(op, 4'd2, 4'd3, 4'd0), '0);
        c           = idle_ctrl();
        c.gra       = 1'b1;
        c.src.r_out = 1'b1;
        c.y_en      = 1'b1;
        push_step(c, '0, CHK_NONE, '0, "");
        c           = idle_ctrl();
        c.grb       = 1'b1;
        c.src.r_out = 1'b1;
        c.z_en      = 1'b1;
        c.op        = op;
        push_step(c, '0, CHK_NONE, '0, "");
        if (op == datapath_pkg::ALU_MUL || op == datapath_pkg::ALU_DIV) begin
            c               = idle_ctrl();
            c.src.zhigh_out = 1'b1;
            c.hi_en         = 1'b1;
            push_step(c, '0, CHK_NONE, '0, "");
            c              = idle_ctrl();
            c.src.zlow_out = 1'b1;
            c.lo_en        = 1'b1;
            push_step(c, '0, CHK_NONE, '0, "");
            c             = idle_ctrl();
            c.src.hi_out  = 1'b1;
            c.out_port_en = 1'b1;
            push_step(c, '0, CHK_WORD, res[63:32], {tag, " via HI"});
            c             = idle_ctrl();
            c.src.lo_out  = 1'b1;
            c.out_port_en = 1'b1;
            push_step(c, '0, CHK_WORD, res[31:0], {tag, " via LO"});
        end else begin
            c              = idle_ctrl();
            c.src.zlow_out = 1'b1;
            c.out_port_en  = 1'b1;
            push_step(c, '0, CHK_WORD, res[31:0], tag);
        end
    endtask

    task automatic store_word(datapath_pkg::word_t addr, datapath_pkg::word_t data);
        datapath_pkg::ctrl_t c;
        push_step(idle_ctrl(), addr, CHK_NONE, '0, "");
        c                 = idle_ctrl();
        c.src.in_port_out = 1'b1;
        c.mar_en          = 1'b1;
        push_step(c, data, CHK_NONE, '0, "");
        c                 = idle_ctrl();
        c.src.in_port_out = 1'b1;
        c.mdr_en          = 1'b1;
        push_step(c, '0, CHK_NONE, '0, "");
        c       = idle_ctrl();
        c.write = 1'b1;
        push_step(c, '0, CHK_NONE, '0, "");
    endtask

    // MDR is clobbered with the address before the memory read
    task automatic read_back(datapath_pkg::word_t addr, datapath_pkg::word_t expected);
        datapath_pkg::ctrl_t c;
        push_step(idle_ctrl(), addr, CHK_NONE, '0, "");
        c                 = idle_ctrl();
        c.src.in_port_out = 1'b1;
        c.mar_en          = 1'b1;
        c.mdr_en          = 1'b1;
        push_step(c, '0, CHK_NONE, '0, "");
        c             = idle_ctrl();
        c.src.mdr_out = 1'b1;
        c.out_port_en = 1'b1;
        push_step(c, '0, CHK_WORD, addr, "MDR overwritten from bus");
        c        = idle_ctrl();
        c.read   = 1'b1;
        c.mdr_en = 1'b1;
        push_step(c, '0, CHK_NONE, '0, "");
        c             = idle_ctrl();
        c.src.mdr_out = 1'b1;
        c.out_port_en = 1'b1;
        push_step(c, '0, CHK_WORD, expected, $sformatf("memory word at %h", addr));
    endtask

    task automatic build_table();
        datapath_pkg::ctrl_t   c;
        datapath_pkg::word_t   v;
        datapath_pkg::word_t   a1;
        datapath_pkg::word_t   d1;
        datapath_pkg::word_t   d2;
        datapath_pkg::word_t   vals [3];
        datapath_pkg::alu_op_t op;
        logic [18:0]           imms [3];

        // PC straight out of reset and after five increments
        c             = idle_ctrl();
        c.src.pc_out  = 1'b1;
        c.out_port_en = 1'b1;
        push_step(c, '0, CHK_WORD, PC_INIT, "PC after reset");
        c        = idle_ctrl();
        c.inc_pc = 1'b1;
        repeat (5) push_step(c, '0, CHK_NONE, '0, "");
        c             = idle_ctrl();
        c.src.pc_out  = 1'b1;
        c.out_port_en = 1'b1;
        push_step(c, '0, CHK_WORD, PC_INIT + 32'd5, "PC after increments");

        // register transfer
        v = $urandom;
        write_reg(4'd9, v);
        c             = idle_ctrl();
        c.gra         = 1'b1;
        c.src.r_out   = 1'b1;
        c.out_port_en = 1'b1;
        push_step(c, '0, CHK_WORD, v, "R9 to output port");

        op = op.first();
        do begin
            run_alu_case(op, $urandom, $urandom);
            op = op.next();
        end while (op != op.first());
        run_alu_case(datapath_pkg::ALU_DIV, 32'hffff_ff85, 32'd7);
        run_alu_case(datapath_pkg::ALU_DIV, $urandom, 32'd0);
        run_alu_case(datapath_pkg::ALU_MUL, 32'h8000_0000, 32'hffff_fffe);

        imms[0] = 19'h12345;
        imms[1] = 19'h7fff0;
        imms[2] = 19'($urandom);
        foreach (imms[i]) begin
            load_ir(encode_b(4'd5, 4'd0, imms[i]), '0);
            c             = idle_ctrl();
            c.src.c_out   = 1'b1;
            c.out_port_en = 1'b1;
            push_step(c, '0, CHK_WORD, sign_extend(imms[i]), "sign-extended immediate");
        end

        // a base register other than R0 passes its value
        v = $urandom | 32'h1;
        write_reg(4'd4, v);
        c             = idle_ctrl();
        c.gra         = 1'b1;
        c.src.ba_out  = 1'b1;
        c.out_port_en = 1'b1;
        push_step(c, '0, CHK_WORD, v, "R4 as base");

        // R0 written and then read as base and as a plain register
        v = $urandom | 32'h1;
        write_reg(4'd0, v);
        c             = idle_ctrl();
        c.gra         = 1'b1;
        c.src.ba_out  = 1'b1;
        c.out_port_en = 1'b1;
        push_step(c, '0, CHK_WORD, '0, "R0 as base reads zero");
        c             = idle_ctrl();
        c.gra         = 1'b1;
        c.src.r_out   = 1'b1;
        c.out_port_en = 1'b1;
        push_step(c, '0, CHK_WORD, v, "R0 as plain register");

        a1 = $urandom % 256;
        d1 = $urandom;
        d2 = ~d1;
        store_word(a1, d1);
        store_word(a1 + 32'd256, d2);
        read_back(a1, d1);
        read_back(a1 + 32'd256, d2);

        vals[0] = '0;
        vals[1] = ($urandom & 32'h7fff_ffff) | 32'h1;
        vals[2] = $urandom | 32'h8000_0000;
        for (int code = 0; code < 4; code++) begin
            foreach (vals[k]) begin
                load_ir(encode_b(4'd0, {2'($urandom), 2'(code)}, 19'd0), vals[k]);
                c                 = idle_ctrl();
                c.src.in_port_out = 1'b1;
                c.con_in          = 1'b1;
                push_step(c, '0, CHK_FLAG, {31'd0, cond_expect(code, vals[k])},
                          $sformatf("con code %0d bus %h", code, vals[k]));
            end
        end
    endtask

    task automatic check_word(datapath_pkg::word_t got, datapath_pkg::word_t want,
            string what);
        if (got !== want) begin
            error_count++;
            $display("FAIL %0t: %s, got %h, expected %h", $time, what, got, want);
            $display("Test FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic check_flag(logic got, logic want, string what);
        if (got !== want) begin
            error_count++;
            $display("FAIL %0t: %s, got %b, expected %b", $time, what, got, want);
            $display("Test FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic check_row(int idx);
        case (steps[idx].kind)
            CHK_WORD: check_word(out_data, steps[idx].expected, labels[idx]);
            CHK_FLAG: check_flag(con, steps[idx].expected[0], labels[idx]);
            default:  ;
        endcase
    endtask

    initial begin
        void'($urandom(SEED));
        reset   <= 1'b1;
        ctrl    <= idle_ctrl();
        in_data <= '0;
        build_table();
        table_ready = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        // each row is checked half a cycle after the edge that ends it
        for (int i = 0; i <= steps.size(); i++) begin
            @(posedge clk);
            if (i < steps.size()) begin
                ctrl    <= steps[i].ctrl;
                in_data <= steps[i].din;
            end else begin
                ctrl <= idle_ctrl();
            end
            @(negedge clk);
            if (i > 0) begin
                check_row(i - 1);
            end
        end
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        longint limit_ns;
        wait (table_ready);
        limit_ns = longint'(steps.size()) * 40 + 8 * 20 + 1000;
        #(limit_ns);
        $display("Timeout: the stimulus table did not complete within %0d ns", limit_ns);
        $display("Test FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule
